//--- include/mbox_regmap.svh
// mailbox register word indexes; needs RFAW >= 6 and at most 16 channels so mbox regs stay below the mask
`ifndef MBOX_REGMAP_SVH
`define MBOX_REGMAP_SVH

// ####################################################################
// data registers, two words per channel
// ####################################################################
localparam int REG_MBOX_BASE = 0;   // chan c: LO at base+2c, HI at base+2c+1

// ####################################################################
// control and status
// ####################################################################
localparam int REG_IRQ_MASK  = 62;  // per-channel irq enable, resets to all ones
localparam int REG_STATUS    = 63;  // write ones to clear overflow bits

// status word layout, one bit per channel in each field
localparam int STAT_NE_LSB   = 0;   // not empty
localparam int STAT_FULL_LSB = 16;  // full
localparam int STAT_OVF_LSB  = 32;  // sticky overflow

`endif

//--- verilog/mbox_pkg.sv
// shared widths, mesh packet layout and types; packet layout is fixed at 104 bits with 32-bit address
package mbox_pkg;

   // ####################################################################
   // widths
   // ####################################################################
   localparam int PW      = 104;       // mesh packet
   localparam int AW      = 32;        // mesh address
   localparam int MBOX_DW = 64;        // mailbox word
   localparam int RFAW    = 6;         // register index, wb byte address is RFAW+2
   localparam int ID_W    = 12;        // link id

   // packet fields, bit positions in the packet
   localparam int CMD_LSB  = 0;
   localparam int CMD_MSB  = 3;
   localparam int ADDR_LSB = 8;
   localparam int ADDR_MSB = 39;
   localparam int DATA_LSB = 40;
   localparam int DATA_MSB = 103;

   // address fields, bit positions in the 32-bit address
   localparam int ID_LSB     = 20;
   localparam int ID_MSB     = 31;
   localparam int REGION_LSB = 8;
   localparam int REGION_MSB = 10;
   localparam int IDX_LSB    = 2;                   // word index, also used on wb_adr
   localparam int IDX_MSB    = IDX_LSB + RFAW - 1;

   localparam logic [2:0] REGION_REGS = 3'h3;      // register space region

   // register map
   `include "mbox_regmap.svh"

   // ####################################################################
   // types
   // ####################################################################
   // mesh commands, bit 1 marks a write
   typedef enum logic [3:0] {
      CMD_READ     = 4'h0,
      CMD_WRITE    = 4'h2,
      CMD_ATOMIC   = 4'h5,
      CMD_RESERVED = 4'hf
   } emesh_cmd_t;

   // wishbone slave states
   typedef enum logic {
      WB_IDLE = 1'b0,
      WB_ACK  = 1'b1
   } wb_state_t;

   typedef logic [MBOX_DW-1:0] mbox_word_t;

endpackage

//--- verilog/emesh_rx_decode.sv
// mesh write filter, no back-pressure; reads, atomics and hi-word writes are silently dropped
`timescale 1ns/1ps

module emesh_rx_decode
   import mbox_pkg::*;
#(
   parameter int              NUM_MBOX = 4,
   parameter logic [ID_W-1:0] LINK_ID  = 12'h810
) (
   input  logic                rd_clk,
   input  logic                rd_reset,
   input  logic                emesh_access,
   input  logic [PW-1:0]       emesh_packet,
   output logic [NUM_MBOX-1:0] push,        // one-hot, one cycle per packet
   output mbox_word_t          push_data
);

   logic [AW-1:0]       pkt_addr;
   emesh_cmd_t          pkt_cmd;
   logic [ID_W-1:0]     pkt_id;
   logic [2:0]          pkt_region;
   logic [RFAW-1:0]     pkt_idx;
   logic [RFAW-1:0]     pkt_off;     // index relative to mailbox base
   mbox_word_t          pkt_data;
   logic                id_hit;
   logic                reg_hit;
   logic                lo_hit;
   logic                hit;
   logic [NUM_MBOX-1:0] push_nxt;

   // ####################################################################
   // field split
   // ####################################################################
   assign pkt_cmd    = emesh_cmd_t'(emesh_packet[CMD_MSB:CMD_LSB]);
   assign pkt_addr   = emesh_packet[ADDR_MSB:ADDR_LSB];
   assign pkt_data   = emesh_packet[DATA_MSB:DATA_LSB];
   assign pkt_id     = pkt_addr[ID_MSB:ID_LSB];
   assign pkt_region = pkt_addr[REGION_MSB:REGION_LSB];
   assign pkt_idx    = pkt_addr[IDX_MSB:IDX_LSB];
   assign pkt_off    = pkt_idx - RFAW'(REG_MBOX_BASE);

   // ####################################################################
   // accept check
   // ####################################################################
   assign id_hit  = (pkt_id == LINK_ID);
   assign reg_hit = (pkt_region == REGION_REGS);   // region 3 only

   // even offset = LO word, must fall inside the channel range
   assign lo_hit = (pkt_idx >= RFAW'(REG_MBOX_BASE))
                 & ~pkt_off[0]
                 & ({1'b0, pkt_off} < (RFAW+1)'(2 * NUM_MBOX));

   assign hit = emesh_access
              & (pkt_cmd == CMD_WRITE)
              & id_hit
              & reg_hit
              & lo_hit;

   // channel number is offset / 2
   always_comb begin
      for (int i = 0; i < NUM_MBOX; i++) begin
         push_nxt[i] = hit && (pkt_off[RFAW-1:1] == (RFAW-1)'(i));
      end
   end

   // ####################################################################
   // pipeline stage
   // ####################################################################
   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         push <= '0;
      end else begin
         push <= push_nxt;   // back-to-back packets ok
      end
   end

   // payload only, qualified by push downstream
   always_ff @(posedge rd_clk) begin
      if (hit) begin
         push_data <= pkt_data;
      end
   end

endmodule

//--- verilog/mbox_channel.sv
// one mailbox fifo; head is combinational from the buffer, a push into a full fifo is lost unless popped
`timescale 1ns/1ps

module mbox_channel
   import mbox_pkg::*;
#(
   parameter int MBOX_DEPTH = 8   // power of two
) (
   input  logic       rd_clk,
   input  logic       rd_reset,
   input  logic       push,
   input  mbox_word_t push_data,
   input  logic       pop,
   input  logic       overflow_clear,
   output mbox_word_t head_data,
   output logic       empty,
   output logic       full,
   output logic       overflow      // sticky until cleared
);

   localparam int PTR_W = (MBOX_DEPTH > 1) ? $clog2(MBOX_DEPTH) : 1;
   localparam int CNT_W = $clog2(MBOX_DEPTH + 1);

   mbox_word_t       mem [MBOX_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_nxt;
   logic             do_push;
   logic             do_pop;
   logic             drop;

   // ####################################################################
   // qualified push / pop
   // ####################################################################
   assign do_pop  = pop & ~empty;              // pop on empty ignored
   assign do_push = push & (~full | do_pop);   // full + pop same cycle still takes it
   assign drop    = push & ~do_push;

   assign count_nxt = count + CNT_W'(do_push) - CNT_W'(do_pop);

   // ####################################################################
   // pointers, wrap explicitly so depth 1 also works
   // ####################################################################
   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         wr_ptr <= '0;
      end else if (do_push) begin
         if (wr_ptr == PTR_W'(MBOX_DEPTH - 1)) begin
            wr_ptr <= '0;
         end else begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         rd_ptr <= '0;
      end else if (do_pop) begin
         if (rd_ptr == PTR_W'(MBOX_DEPTH - 1)) begin
            rd_ptr <= '0;
         end else begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // occupancy and flags, all registered
   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         count <= '0;
         empty <= 1'b1;
         full  <= 1'b0;
      end else begin
         count <= count_nxt;
         empty <= (count_nxt == '0);
         full  <= (count_nxt == CNT_W'(MBOX_DEPTH));
      end
   end

   // a drop in the same cycle as a clear wins, event is not lost
   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         overflow <= 1'b0;
      end else if (drop) begin
         overflow <= 1'b1;
      end else if (overflow_clear) begin
         overflow <= 1'b0;
      end
   end

   // ####################################################################
   // storage
   // ####################################################################
   always_ff @(posedge rd_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   assign head_data = mem[rd_ptr];   // stale when empty, slave masks it

endmodule

//--- verilog/mbox_wb_regs.sv
// wishbone classic slave, fixed one-cycle ack then one idle cycle; no bursts, no byte enables, adr[1:0] ignored
`timescale 1ns/1ps

module mbox_wb_regs
   import mbox_pkg::*;
#(
   parameter int NUM_MBOX = 4
) (
   input  logic                             rd_clk,
   input  logic                             rd_reset,
   input  logic                             wb_cyc,
   input  logic                             wb_stb,
   input  logic                             wb_we,
   input  logic [RFAW+1:0]                  wb_adr,    // byte address
   input  mbox_word_t                       wb_wdata,
   input  logic [NUM_MBOX-1:0][MBOX_DW-1:0] head_data,
   input  logic [NUM_MBOX-1:0]              empty,
   input  logic [NUM_MBOX-1:0]              full,
   input  logic [NUM_MBOX-1:0]              overflow,
   output logic                             wb_ack,
   output mbox_word_t                       wb_rdata,
   output logic [NUM_MBOX-1:0]              pop,
   output logic [NUM_MBOX-1:0]              overflow_clear,
   output logic                             mailbox_irq,
   output logic [NUM_MBOX-1:0]              mailbox_not_empty,
   output logic [NUM_MBOX-1:0]              mailbox_full
);

   wb_state_t           state;
   logic                req;
   logic                rd_req;
   logic                wr_req;
   logic [RFAW-1:0]     reg_idx;
   logic [RFAW-1:0]     reg_off;
   logic                is_mbox;
   logic                is_hi;
   logic [RFAW-2:0]     chan;
   logic                wr_mask;
   logic                wr_status;
   mbox_word_t          status_word;
   mbox_word_t          rd_mux;
   logic [NUM_MBOX-1:0] pop_nxt;
   logic [NUM_MBOX-1:0] irq_mask;

   // ####################################################################
   // handshake
   // ####################################################################
   assign req    = wb_cyc & wb_stb & (state == WB_IDLE);   // only sampled in idle
   assign rd_req = req & ~wb_we;
   assign wr_req = req & wb_we;

   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         state <= WB_IDLE;
      end else begin
         case (state)
            WB_IDLE: if (req) state <= WB_ACK;
            WB_ACK:  state <= WB_IDLE;   // forced gap cycle
            default: state <= WB_IDLE;
         endcase
      end
   end

   assign wb_ack = (state == WB_ACK);

   // ####################################################################
   // address decode
   // ####################################################################
   assign reg_idx   = wb_adr[IDX_MSB:IDX_LSB];
   assign reg_off   = reg_idx - RFAW'(REG_MBOX_BASE);
   assign is_mbox   = (reg_idx >= RFAW'(REG_MBOX_BASE))
                    & ({1'b0, reg_off} < (RFAW+1)'(2 * NUM_MBOX));
   assign is_hi     = reg_off[0];          // odd = HI, pops
   assign chan      = reg_off[RFAW-1:1];
   assign wr_mask   = wr_req & (reg_idx == RFAW'(REG_IRQ_MASK));
   assign wr_status = wr_req & (reg_idx == RFAW'(REG_STATUS));

   // status word, unused channel bits read zero
   always_comb begin
      status_word = '0;
      for (int i = 0; i < NUM_MBOX; i++) begin
         status_word[STAT_NE_LSB + i]   = ~empty[i];
         status_word[STAT_FULL_LSB + i] = full[i];
         status_word[STAT_OVF_LSB + i]  = overflow[i];
      end
   end

   // read mux, empty channel reads zero and never pops
   always_comb begin
      rd_mux  = '0;
      pop_nxt = '0;
      if (is_mbox) begin
         for (int i = 0; i < NUM_MBOX; i++) begin
            if (chan == (RFAW-1)'(i) && !empty[i]) begin
               rd_mux     = head_data[i];
               pop_nxt[i] = is_hi;
            end
         end
      end else if (reg_idx == RFAW'(REG_IRQ_MASK)) begin
         rd_mux = MBOX_DW'(irq_mask);
      end else if (reg_idx == RFAW'(REG_STATUS)) begin
         rd_mux = status_word;
      end
   end

   // ####################################################################
   // registered outputs, pop/clear pulse during the ack cycle
   // ####################################################################
   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         wb_rdata       <= '0;
         pop            <= '0;
         overflow_clear <= '0;
      end else begin
         wb_rdata       <= rd_req ? rd_mux : '0;    // zero outside ack
         pop            <= rd_req ? pop_nxt : '0;   // fifo pops at end of ack
         overflow_clear <= wr_status ? wb_wdata[STAT_OVF_LSB +: NUM_MBOX] : '0;
      end
   end

   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         irq_mask <= '1;   // all enabled out of reset
      end else if (wr_mask) begin
         irq_mask <= wb_wdata[NUM_MBOX-1:0];
      end
   end

   // level irq, one cycle behind the flags
   always_ff @(posedge rd_clk) begin
      if (rd_reset) begin
         mailbox_irq <= 1'b0;
      end else begin
         mailbox_irq <= |(~empty & irq_mask);
      end
   end

   assign mailbox_not_empty = ~empty;
   assign mailbox_full      = full;

endmodule

//--- verilog/emailbox_top.sv
// mailbox top, single clock rd_clk; NUM_MBOX 1..16, MBOX_DEPTH a power of two
`timescale 1ns/1ps

module emailbox_top
   import mbox_pkg::*;
#(
   parameter int              NUM_MBOX   = 4,
   parameter int              MBOX_DEPTH = 8,
   parameter logic [ID_W-1:0] LINK_ID    = 12'h810
) (
   input  logic                rd_clk,
   input  logic                rd_reset,
   // mesh rx, no back-pressure
   input  logic                emesh_access,
   input  logic [PW-1:0]       emesh_packet,
   // wishbone slave
   input  logic                wb_cyc,
   input  logic                wb_stb,
   input  logic                wb_we,
   input  logic [RFAW+1:0]     wb_adr,
   input  mbox_word_t          wb_wdata,
   output logic                wb_ack,
   output mbox_word_t          wb_rdata,
   // interrupt and flags
   output logic                mailbox_irq,
   output logic [NUM_MBOX-1:0] mailbox_not_empty,
   output logic [NUM_MBOX-1:0] mailbox_full
);

   logic [NUM_MBOX-1:0]              push;
   mbox_word_t                       push_data;
   logic [NUM_MBOX-1:0][MBOX_DW-1:0] head_data;
   logic [NUM_MBOX-1:0]              empty;
   logic [NUM_MBOX-1:0]              full;
   logic [NUM_MBOX-1:0]              overflow;
   logic [NUM_MBOX-1:0]              pop;
   logic [NUM_MBOX-1:0]              overflow_clear;

   emesh_rx_decode #(
      .NUM_MBOX (NUM_MBOX),
      .LINK_ID  (LINK_ID)
   ) emesh_rx_decode_i (
      .rd_clk       (rd_clk),
      .rd_reset     (rd_reset),
      .emesh_access (emesh_access),
      .emesh_packet (emesh_packet),
      .push         (push),
      .push_data    (push_data)
   );

   // one fifo per channel, shared push payload
   for (genvar c = 0; c < NUM_MBOX; c++) begin : g_chan
      mbox_channel #(
         .MBOX_DEPTH (MBOX_DEPTH)
      ) mbox_channel_i (
         .rd_clk         (rd_clk),
         .rd_reset       (rd_reset),
         .push           (push[c]),
         .push_data      (push_data),
         .pop            (pop[c]),
         .overflow_clear (overflow_clear[c]),
         .head_data      (head_data[c]),
         .empty          (empty[c]),
         .full           (full[c]),
         .overflow       (overflow[c])
      );
   end

   mbox_wb_regs #(
      .NUM_MBOX (NUM_MBOX)
   ) mbox_wb_regs_i (
      .rd_clk            (rd_clk),
      .rd_reset          (rd_reset),
      .wb_cyc            (wb_cyc),
      .wb_stb            (wb_stb),
      .wb_we             (wb_we),
      .wb_adr            (wb_adr),
      .wb_wdata          (wb_wdata),
      .head_data         (head_data),
      .empty             (empty),
      .full              (full),
      .overflow          (overflow),
      .wb_ack            (wb_ack),
      .wb_rdata          (wb_rdata),
      .pop               (pop),
      .overflow_clear    (overflow_clear),
      .mailbox_irq       (mailbox_irq),
      .mailbox_not_empty (mailbox_not_empty),
      .mailbox_full      (mailbox_full)
   );

endmodule

//--- dv/emailbox_tb.sv
// self-checking testbench for 4 channels of depth 8 at link 12'h810; stops at the first mismatch
`timescale 1ns/1ps

module emailbox_tb
   import mbox_pkg::*;
();

   localparam int              NUM_MBOX   = 4;
   localparam int              MBOX_DEPTH = 8;
   localparam logic [ID_W-1:0] LINK       = 12'h810;
   localparam int              NUM_RAND   = 400;
   localparam int              NUM_OPS    = 650;                  // directed + random bus/packet ops
   localparam int              WATCHDOG   = NUM_OPS * 20 + 1000;  // cycles
   localparam int              ACK_LIMIT  = 16;

   logic                rd_clk;
   logic                rd_reset;
   logic                emesh_access;
   logic [PW-1:0]       emesh_packet;
   logic                wb_cyc;
   logic                wb_stb;
   logic                wb_we;
   logic [RFAW+1:0]     wb_adr;
   mbox_word_t          wb_wdata;
   logic                wb_ack;
   mbox_word_t          wb_rdata;
   logic                mailbox_irq;
   logic [NUM_MBOX-1:0] mailbox_not_empty;
   logic [NUM_MBOX-1:0] mailbox_full;

   // reference model
   mbox_word_t          model_q [NUM_MBOX][$];
   logic [NUM_MBOX-1:0] model_ovf;
   logic [NUM_MBOX-1:0] model_mask;

   emailbox_top #(
      .NUM_MBOX   (NUM_MBOX),
      .MBOX_DEPTH (MBOX_DEPTH),
      .LINK_ID    (LINK)
   ) emailbox_top_i (
      .rd_clk            (rd_clk),
      .rd_reset          (rd_reset),
      .emesh_access      (emesh_access),
      .emesh_packet      (emesh_packet),
      .wb_cyc            (wb_cyc),
      .wb_stb            (wb_stb),
      .wb_we             (wb_we),
      .wb_adr            (wb_adr),
      .wb_wdata          (wb_wdata),
      .wb_ack            (wb_ack),
      .wb_rdata          (wb_rdata),
      .mailbox_irq       (mailbox_irq),
      .mailbox_not_empty (mailbox_not_empty),
      .mailbox_full      (mailbox_full)
   );

   initial begin
      rd_clk = 1'b0;
      forever #2 rd_clk = ~rd_clk;   // 4 ns period
   end

   initial begin
      repeat (WATCHDOG) @(posedge rd_clk);
      fail_run($sformatf("timeout, run did not finish within %0d cycles", WATCHDOG));
   end

   // ####################################################################
   // failure and compare tasks
   // ####################################################################
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_data(input string what, input mbox_word_t got, input mbox_word_t want);
      if (got !== want) begin
         fail_run($sformatf("mismatch at %0t: %s read %h, expected %h", $time, what, got, want));
      end
   endtask

   task automatic check_status(input string what, input logic [MBOX_DW-1:0] got,
                               input logic [MBOX_DW-1:0] want);
      if (got !== want) begin
         fail_run($sformatf("mismatch at %0t: %s status %h, expected %h", $time, what, got, want));
      end
   endtask

   task automatic check_flags(input string what, input logic [NUM_MBOX-1:0] got,
                              input logic [NUM_MBOX-1:0] want);
      if (got !== want) begin
         fail_run($sformatf("mismatch at %0t: %s flags %b, expected %b", $time, what, got, want));
      end
   endtask

   task automatic check_irq(input string what, input logic got, input logic want);
      if (got !== want) begin
         fail_run($sformatf("mismatch at %0t: %s irq %b, expected %b", $time, what, got, want));
      end
   endtask

   // ####################################################################
   // model
   // ####################################################################
   function automatic logic [MBOX_DW-1:0] model_status();
      logic [MBOX_DW-1:0] s;
      s = '0;
      for (int c = 0; c < NUM_MBOX; c++) begin
         s[c]      = (model_q[c].size() != 0);
         s[16 + c] = (model_q[c].size() == MBOX_DEPTH);
         s[32 + c] = model_ovf[c];
      end
      return s;
   endfunction

   // write to own id, region 3, even LO index of a real channel
   function automatic int route(input emesh_cmd_t cmd, input logic [ID_W-1:0] id,
                                input logic [2:0] region, input logic [RFAW-1:0] idx);
      if (cmd == CMD_WRITE && id == LINK && region == 3'd3 && !idx[0] && idx < 2 * NUM_MBOX) begin
         return idx / 2;
      end
      return -1;
   endfunction

   // ####################################################################
   // drivers, all on the falling edge
   // ####################################################################
   task automatic send_packet(input emesh_cmd_t cmd, input logic [ID_W-1:0] id,
                              input logic [2:0] region, input logic [RFAW-1:0] idx,
                              input mbox_word_t d);
      logic [PW-1:0] pkt;
      int            c;
      pkt          = '0;
      pkt[3:0]     = cmd;
      pkt[39:28]   = id;       // addr 31:20
      pkt[18:16]   = region;   // addr 10:8
      pkt[15:10]   = idx;      // addr 7:2
      pkt[103:40]  = d;
      @(negedge rd_clk);
      emesh_access = 1'b1;
      emesh_packet = pkt;
      c = route(cmd, id, region, idx);
      if (c >= 0) begin
         if (model_q[c].size() == MBOX_DEPTH) begin
            model_ovf[c] = 1'b1;   // dropped
         end else begin
            model_q[c].push_back(d);
         end
      end
   endtask

   task automatic end_burst();
      @(negedge rd_clk);
      emesh_access = 1'b0;
      repeat (3) @(negedge rd_clk);   // decode + fifo + irq stages
   endtask

   task automatic wb_access(input logic we, input logic [RFAW-1:0] idx, input mbox_word_t wdata,
                            output mbox_word_t rdata);
      int        waited;
      wb_state_t st;
      @(negedge rd_clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = {idx, 2'b00};
      wb_wdata = wdata;
      waited   = 0;
      do begin
         @(negedge rd_clk);
         waited++;
         if (waited > ACK_LIMIT) begin
            st = emailbox_top_i.mbox_wb_regs_i.state;
            fail_run($sformatf("no wb_ack after %0d cycles, slave in %s", ACK_LIMIT, st.name()));
         end
      end while (!wb_ack);
      rdata  = wb_rdata;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input logic [RFAW-1:0] idx, input mbox_word_t d);
      mbox_word_t unused;
      wb_access(1'b1, idx, d, unused);
      if (idx == REG_IRQ_MASK) model_mask = d[NUM_MBOX-1:0];
      if (idx == REG_STATUS) model_ovf = model_ovf & ~d[32 +: NUM_MBOX];   // write ones to clear
   endtask

   // LO keeps the head, HI pops it; empty reads zero
   task automatic read_chan(input int c, input bit hi);
      mbox_word_t got;
      mbox_word_t want;
      want = (model_q[c].size() > 0) ? model_q[c][0] : '0;
      wb_access(1'b0, RFAW'(2 * c + hi), '0, got);
      check_data($sformatf("chan %0d %s", c, hi ? "HI" : "LO"), got, want);
      if (hi && model_q[c].size() > 0) void'(model_q[c].pop_front());
   endtask

   task automatic read_zero(input logic [RFAW-1:0] idx);
      mbox_word_t got;
      wb_access(1'b0, idx, '0, got);
      check_data($sformatf("index %0d", idx), got, '0);
   endtask

   // status, mask, flag outputs and irq against the model
   task automatic check_regs(input string where);
      mbox_word_t          got;
      logic [NUM_MBOX-1:0] ne;
      logic [NUM_MBOX-1:0] fl;
      wb_access(1'b0, REG_STATUS, '0, got);
      check_status(where, got, model_status());
      wb_access(1'b0, REG_IRQ_MASK, '0, got);
      check_data({where, " mask"}, got, MBOX_DW'(model_mask));
      repeat (2) @(negedge rd_clk);   // irq is one cycle behind the flags
      for (int c = 0; c < NUM_MBOX; c++) begin
         ne[c] = (model_q[c].size() != 0);
         fl[c] = (model_q[c].size() == MBOX_DEPTH);
      end
      check_flags({where, " not empty"}, mailbox_not_empty, ne);
      check_flags({where, " full"}, mailbox_full, fl);
      check_irq(where, mailbox_irq, |(ne & model_mask));
   endtask

   // ####################################################################
   // test sequence
   // ####################################################################
   initial begin
      int          op;
      int          c;
      mbox_word_t  w;
      emesh_cmd_t  cmd;
      logic [ID_W-1:0] id;
      logic [2:0]  region;
      rd_reset     = 1'b1;
      emesh_access = 1'b0;
      emesh_packet = '0;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_we        = 1'b0;
      wb_adr       = '0;
      wb_wdata     = '0;
      model_ovf    = '0;
      model_mask   = '1;
      op = $urandom(77792);   // seed once
      repeat (4) @(negedge rd_clk);
      rd_reset = 1'b0;
      check_regs("after reset");

      // fifo order, LO peek then HI pop
      for (int i = 0; i < 3; i++) begin
         for (int k = 0; k < NUM_MBOX; k++) begin
            send_packet(CMD_WRITE, LINK, 3'd3, 2 * k, {$urandom, $urandom});
         end
      end
      end_burst();
      check_regs("routed writes");
      for (int k = 0; k < NUM_MBOX; k++) begin
         for (int i = 0; i < 3; i++) begin
            read_chan(k, 1'b0);
            read_chan(k, 1'b1);
         end
      end
      check_regs("drained");

      // packets that must be dropped
      send_packet(CMD_READ, LINK, 3'd3, 0, 64'h1);
      send_packet(CMD_ATOMIC, LINK, 3'd3, 2, 64'h2);
      send_packet(CMD_RESERVED, LINK, 3'd3, 4, 64'h3);
      send_packet(CMD_WRITE, LINK ^ 12'h001, 3'd3, 0, 64'h4);
      send_packet(CMD_WRITE, LINK, 3'd2, 2, 64'h5);
      send_packet(CMD_WRITE, LINK, 3'd3, 3, 64'h6);    // HI index
      send_packet(CMD_WRITE, LINK, 3'd3, 8, 64'h7);    // channel 4
      send_packet(CMD_WRITE, LINK, 3'd3, 14, 64'h8);
      end_burst();
      check_regs("dropped packets");
      for (int k = 0; k < NUM_MBOX; k++) read_chan(k, 1'b1);

      // overflow on channel 1, clear keeps the data
      for (int i = 0; i < 9; i++) send_packet(CMD_WRITE, LINK, 3'd3, 2, {$urandom, $urandom});
      end_burst();
      check_regs("overflow");
      wb_write(REG_STATUS, '1);
      check_regs("overflow clear");
      for (int i = 0; i < MBOX_DEPTH; i++) begin
         read_chan(1, 1'b0);
         read_chan(1, 1'b1);
      end
      check_regs("channel 1 drained");

      // irq gating
      send_packet(CMD_WRITE, LINK, 3'd3, 0, {$urandom, $urandom});
      send_packet(CMD_WRITE, LINK, 3'd3, 4, {$urandom, $urandom});
      end_burst();
      wb_write(REG_IRQ_MASK, 64'h2);
      check_regs("mask 2");
      wb_write(REG_IRQ_MASK, 64'h4);
      check_regs("mask 4");
      read_chan(2, 1'b1);
      check_regs("chan 2 drained");
      wb_write(REG_IRQ_MASK, 64'hf);
      check_regs("mask f");
      read_chan(0, 1'b1);
      check_regs("chan 0 drained");

      // empty channel and unmapped indexes
      read_chan(3, 1'b0);
      read_chan(3, 1'b1);
      read_zero(8);
      read_zero(33);
      read_zero(61);
      wb_write(9, '1);   // ignored
      check_regs("unmapped write");

      // random mix
      for (int n = 0; n < NUM_RAND; n++) begin
         op = $urandom_range(0, 7);
         c  = $urandom_range(0, NUM_MBOX - 1);
         if (op < 3) begin
            for (int i = $urandom_range(1, 3); i > 0; i--) begin
               cmd    = ($urandom_range(0, 9) < 8) ? CMD_WRITE : CMD_ATOMIC;
               id     = ($urandom_range(0, 7) == 0) ? LINK ^ 12'h100 : LINK;
               region = ($urandom_range(0, 7) == 0) ? 3'd1 : 3'd3;
               send_packet(cmd, id, region, $urandom_range(0, 9), {$urandom, $urandom});
            end
            end_burst();
         end else if (op == 3) begin
            read_chan(c, 1'b0);
         end else if (op < 6) begin
            read_chan(c, 1'b1);
         end else if (op == 6) begin
            w = {$urandom, $urandom};
            wb_write(REG_IRQ_MASK, w);
         end else begin
            w = {$urandom, $urandom};
            wb_write(REG_STATUS, w);
         end
         check_regs($sformatf("random op %0d", n));
      end
      $display("Test passed");
      $finish;
   end

endmodule

//--- project.f
+incdir+include
verilog/mbox_pkg.sv
verilog/emesh_rx_decode.sv
verilog/mbox_channel.sv
verilog/mbox_wb_regs.sv
verilog/emailbox_top.sv
dv/emailbox_tb.sv
